//--- cpu_pkg.sv
package cpu_pkg;

    localparam int INSTR_W  = 32;
    localparam int NUM_REGS = 16;

    // instruction field positions
    localparam int COND_HI    = 31;
    localparam int COND_LO    = 28;
    localparam int OP_HI      = 27;
    localparam int OP_LO      = 23;
    localparam int REG_A_HI   = 22;
    localparam int REG_A_LO   = 19;
    localparam int REG_B_HI   = 18;
    localparam int REG_B_LO   = 15;
    localparam int REG_C_HI   = 14;
    localparam int REG_C_LO   = 11;
    localparam int SET_ST_BIT = 10;
    localparam int IMM8_HI    = 7;
    localparam int IMM8_LO    = 0;
    localparam int IMM16_HI   = 15;
    localparam int IMM16_LO   = 0;

    // codes past OP_HALT decode as nop
    typedef enum logic [4:0] {
        OP_NOP, OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOT,
        OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_RSUBI,
        OP_SHL, OP_SHLI, OP_SHR, OP_SHRI, OP_ASHR, OP_ASHRI,
        OP_LD, OP_LDI, OP_ST, OP_LDR, OP_STR, OP_PUSH, OP_POP, OP_MOV,
        OP_HALT
    } opcode_e;

    // carry set means no borrow after a subtract
    typedef enum logic [3:0] {
        COND_NONE, COND_EQ, COND_NE,
        COND_LTU, COND_GTU, COND_LEU, COND_GEU,
        COND_LTS, COND_GTS, COND_LES, COND_GES
    } cond_e;

    typedef enum logic [3:0] {
        R0, R1, R2, R3, R4, R5, R6, R7,
        R8, R9, R10, R11, R12, R13,
        SP = 4'd14,
        PC = 4'd15
    } reg_e;

    typedef enum logic [3:0] {
        ALU_PASSA, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
        ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR, ALU_ASHR
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } status_t;

endpackage

//--- ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if import cpu_pkg::*; ();

    reg_e        sel_a;
    reg_e        sel_b;
    reg_e        sel_in;
    logic        oe_a_reg;
    logic        oe_b_reg;
    logic        ld_reg;
    // signed step applied to the port b register
    logic [7:0]  count_b;
    logic        pre_count_b;
    logic        post_count_b;
    logic        ld_from_mem;
    logic        addr_from_imm;
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic        imm_a_en;
    logic        imm_b_en;
    alu_op_e     alu_op;
    logic        ld_status;

    modport cu (
        output sel_a, sel_b, sel_in, oe_a_reg, oe_b_reg, ld_reg,
        output count_b, pre_count_b, post_count_b, ld_from_mem, addr_from_imm,
        output imm_a, imm_b, imm_a_en, imm_b_en, alu_op, ld_status
    );

    modport rf (
        input sel_a, sel_b, sel_in, oe_a_reg, oe_b_reg, ld_reg,
        input count_b, pre_count_b, post_count_b, ld_from_mem, addr_from_imm, imm_b
    );

    modport alu (
        input imm_a, imm_b, imm_a_en, imm_b_en, alu_op, ld_status
    );

endinterface

//--- control_unit.sv
`timescale 1ns/1ns

module control_unit import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               start_i,
    input  logic [INSTR_W-1:0] instr_i,
    input  status_t            status_i,
    output logic               mem_rd_o,
    output logic               mem_wr_o,
    output logic               halted_o,
    ctrl_if.cu                 ctrl
);

    typedef enum logic [1:0] {
        ST_STOP,
        ST_FETCH,
        ST_EXEC
    } state_e;

    state_e             state_q;
    logic [INSTR_W-1:0] ir_q;
    opcode_e            fetch_op;
    cond_e              fetch_cond;
    opcode_e            exec_op;
    reg_e               reg_a;
    reg_e               reg_b;
    reg_e               reg_c;
    logic               set_status;
    logic [15:0]        imm8;
    logic [15:0]        imm16;

    function automatic logic cond_ok(input cond_e cond, input status_t s);
        logic lt_s;
        lt_s = s.negative ^ s.overflow;
        case (cond)
            COND_EQ:  cond_ok = s.zero;
            COND_NE:  cond_ok = !s.zero;
            COND_LTU: cond_ok = !s.carry;
            COND_GTU: cond_ok = s.carry && !s.zero;
            COND_LEU: cond_ok = !s.carry || s.zero;
            COND_GEU: cond_ok = s.carry;
            COND_LTS: cond_ok = lt_s;
            COND_GTS: cond_ok = !s.zero && !lt_s;
            COND_LES: cond_ok = s.zero || lt_s;
            COND_GES: cond_ok = !lt_s;
            default:  cond_ok = 1'b1;
        endcase
    endfunction

    function automatic alu_op_e alu_op_for(input opcode_e op);
        case (op)
            OP_AND, OP_ANDI:           alu_op_for = ALU_AND;
            OP_OR, OP_ORI:             alu_op_for = ALU_OR;
            OP_XOR, OP_XORI:           alu_op_for = ALU_XOR;
            OP_NOT:                    alu_op_for = ALU_NOT;
            OP_ADD, OP_ADDI:           alu_op_for = ALU_ADD;
            OP_SUB, OP_SUBI, OP_RSUBI: alu_op_for = ALU_SUB;
            OP_SHL, OP_SHLI:           alu_op_for = ALU_SHL;
            OP_SHR, OP_SHRI:           alu_op_for = ALU_SHR;
            OP_ASHR, OP_ASHRI:         alu_op_for = ALU_ASHR;
            default:                   alu_op_for = ALU_PASSA;
        endcase
    endfunction

    // decode of the word on the bus during fetch
    assign fetch_op   = opcode_e'(instr_i[OP_HI:OP_LO]);
    assign fetch_cond = cond_e'(instr_i[COND_HI:COND_LO]);

    assign exec_op    = opcode_e'(ir_q[OP_HI:OP_LO]);
    assign reg_a      = reg_e'(ir_q[REG_A_HI:REG_A_LO]);
    assign reg_b      = reg_e'(ir_q[REG_B_HI:REG_B_LO]);
    assign reg_c      = reg_e'(ir_q[REG_C_HI:REG_C_LO]);
    assign set_status = ir_q[SET_ST_BIT];
    assign imm8       = {8'h00, ir_q[IMM8_HI:IMM8_LO]};
    assign imm16      = ir_q[IMM16_HI:IMM16_LO];
    assign halted_o   = (state_q == ST_STOP);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_STOP;
        end else begin
            case (state_q)
                ST_STOP: begin
                    if (start_i) begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // nop, unused codes and failed conditions fetch again
                    if (cond_ok(fetch_cond, status_i)) begin
                        if (fetch_op == OP_HALT) begin
                            state_q <= ST_STOP;
                        end else if (fetch_op inside {[OP_AND:OP_MOV]}) begin
                            state_q <= ST_EXEC;
                        end
                    end
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FETCH) begin
            ir_q <= instr_i;
        end
    end

    always_comb begin
        ctrl.sel_a         = R0;
        ctrl.sel_b         = R0;
        ctrl.sel_in        = R0;
        ctrl.oe_a_reg      = 1'b0;
        ctrl.oe_b_reg      = 1'b0;
        ctrl.ld_reg        = 1'b0;
        ctrl.count_b       = 8'd0;
        ctrl.pre_count_b   = 1'b0;
        ctrl.post_count_b  = 1'b0;
        ctrl.ld_from_mem   = 1'b0;
        ctrl.addr_from_imm = 1'b0;
        ctrl.imm_a         = 16'h0000;
        ctrl.imm_b         = 16'h0000;
        ctrl.imm_a_en      = 1'b0;
        ctrl.imm_b_en      = 1'b0;
        ctrl.alu_op        = ALU_PASSA;
        ctrl.ld_status     = 1'b0;
        mem_rd_o           = 1'b0;
        mem_wr_o           = 1'b0;

        if (state_q == ST_FETCH) begin
            // ir <- mem[pc++]
            ctrl.sel_b        = PC;
            ctrl.oe_b_reg     = 1'b1;
            ctrl.count_b      = 8'd1;
            ctrl.post_count_b = 1'b1;
            mem_rd_o          = 1'b1;
        end else if (state_q == ST_EXEC) begin
            ctrl.alu_op = alu_op_for(exec_op);
            case (exec_op)
                OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_ASHR: begin
                    ctrl.sel_a     = reg_b;
                    ctrl.oe_a_reg  = 1'b1;
                    ctrl.sel_b     = reg_c;
                    ctrl.oe_b_reg  = 1'b1;
                    ctrl.sel_in    = reg_a;
                    ctrl.ld_reg    = 1'b1;
                    ctrl.ld_status = set_status;
                end
                OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_SUBI, OP_SHLI, OP_SHRI, OP_ASHRI: begin
                    ctrl.sel_a     = reg_b;
                    ctrl.oe_a_reg  = 1'b1;
                    ctrl.imm_b     = imm8;
                    ctrl.imm_b_en  = 1'b1;
                    ctrl.sel_in    = reg_a;
                    ctrl.ld_reg    = 1'b1;
                    ctrl.ld_status = set_status;
                end
                OP_RSUBI: begin
                    ctrl.imm_a     = imm8;
                    ctrl.imm_a_en  = 1'b1;
                    ctrl.sel_b     = reg_b;
                    ctrl.oe_b_reg  = 1'b1;
                    ctrl.sel_in    = reg_a;
                    ctrl.ld_reg    = 1'b1;
                    ctrl.ld_status = set_status;
                end
                OP_NOT: begin
                    ctrl.sel_a     = reg_b;
                    ctrl.oe_a_reg  = 1'b1;
                    ctrl.sel_in    = reg_a;
                    ctrl.ld_reg    = 1'b1;
                    ctrl.ld_status = set_status;
                end
                OP_LD: begin
                    ctrl.imm_b         = imm16;
                    ctrl.addr_from_imm = 1'b1;
                    ctrl.ld_from_mem   = 1'b1;
                    ctrl.sel_in        = reg_a;
                    ctrl.ld_reg        = 1'b1;
                    mem_rd_o           = 1'b1;
                end
                OP_LDI: begin
                    ctrl.imm_a    = imm16;
                    ctrl.imm_a_en = 1'b1;
                    ctrl.sel_in   = reg_a;
                    ctrl.ld_reg   = 1'b1;
                end
                OP_ST: begin
                    ctrl.sel_a         = reg_a;
                    ctrl.oe_a_reg      = 1'b1;
                    ctrl.imm_b         = imm16;
                    ctrl.addr_from_imm = 1'b1;
                    mem_wr_o           = 1'b1;
                end
                OP_LDR: begin
                    ctrl.sel_b       = reg_b;
                    ctrl.oe_b_reg    = 1'b1;
                    ctrl.ld_from_mem = 1'b1;
                    ctrl.sel_in      = reg_a;
                    ctrl.ld_reg      = 1'b1;
                    mem_rd_o         = 1'b1;
                end
                OP_STR: begin
                    ctrl.sel_a    = reg_a;
                    ctrl.oe_a_reg = 1'b1;
                    ctrl.sel_b    = reg_b;
                    ctrl.oe_b_reg = 1'b1;
                    mem_wr_o      = 1'b1;
                end
                OP_PUSH: begin
                    // mem[--sp] <- reg_a
                    ctrl.sel_a       = reg_a;
                    ctrl.oe_a_reg    = 1'b1;
                    ctrl.sel_b       = SP;
                    ctrl.oe_b_reg    = 1'b1;
                    ctrl.count_b     = 8'hff;
                    ctrl.pre_count_b = 1'b1;
                    mem_wr_o         = 1'b1;
                end
                OP_POP: begin
                    // reg_a <- mem[sp++]
                    ctrl.sel_b        = SP;
                    ctrl.oe_b_reg     = 1'b1;
                    ctrl.count_b      = 8'd1;
                    ctrl.post_count_b = 1'b1;
                    ctrl.ld_from_mem  = 1'b1;
                    ctrl.sel_in       = reg_a;
                    ctrl.ld_reg       = 1'b1;
                    mem_rd_o          = 1'b1;
                end
                OP_MOV: begin
                    ctrl.sel_a    = reg_b;
                    ctrl.oe_a_reg = 1'b1;
                    ctrl.sel_in   = reg_a;
                    ctrl.ld_reg   = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_i,
    ctrl_if.rf                ctrl,
    input  logic [DATA_W-1:0] alu_result_i,
    input  logic [DATA_W-1:0] mem_rdata_i,
    output logic [DATA_W-1:0] rd_a_o,
    output logic [DATA_W-1:0] rd_b_o,
    output logic [ADDR_W-1:0] mem_addr_o
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [DATA_W-1:0] step;
    logic [DATA_W-1:0] b_cur;
    logic [DATA_W-1:0] b_next;
    logic [DATA_W-1:0] imm_addr;
    logic [DATA_W-1:0] wb_data;

    assign step   = {{(DATA_W-8){ctrl.count_b[7]}}, ctrl.count_b};
    assign b_cur  = regs[ctrl.sel_b];
    assign b_next = b_cur + step;

    assign rd_a_o = ctrl.oe_a_reg ? regs[ctrl.sel_a] : '0;
    // pre-count shows the new value in the same cycle
    assign rd_b_o = !ctrl.oe_b_reg ? '0 : (ctrl.pre_count_b ? b_next : b_cur);

    assign imm_addr   = DATA_W'(ctrl.imm_b);
    assign mem_addr_o = ctrl.addr_from_imm ? imm_addr[ADDR_W-1:0] : rd_b_o[ADDR_W-1:0];
    assign wb_data    = ctrl.ld_from_mem ? mem_rdata_i : alu_result_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ctrl.pre_count_b || ctrl.post_count_b) begin
                regs[ctrl.sel_b] <= b_next;
            end
            // write-back wins over the count when pop targets sp
            if (ctrl.ld_reg) begin
                regs[ctrl.sel_in] <= wb_data;
            end
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_i,
    ctrl_if.alu               ctrl,
    input  logic [DATA_W-1:0] rd_a_i,
    input  logic [DATA_W-1:0] rd_b_i,
    output logic [DATA_W-1:0] result_o,
    output status_t           status_o
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] res;
    logic [DATA_W:0]   wide;
    logic [4:0]        shamt;
    logic              ovf;
    status_t           status_q;

    assign op_a  = ctrl.imm_a_en ? DATA_W'(ctrl.imm_a) : rd_a_i;
    assign op_b  = ctrl.imm_b_en ? DATA_W'(ctrl.imm_b) : rd_b_i;
    assign shamt = op_b[4:0];

    always_comb begin
        wide = '0;
        ovf  = 1'b0;
        case (ctrl.alu_op)
            ALU_AND:  res = op_a & op_b;
            ALU_OR:   res = op_a | op_b;
            ALU_XOR:  res = op_a ^ op_b;
            ALU_NOT:  res = ~op_a;
            ALU_ADD: begin
                wide = {1'b0, op_a} + {1'b0, op_b};
                res  = wide[DATA_W-1:0];
                ovf  = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (res[DATA_W-1] != op_a[DATA_W-1]);
            end
            ALU_SUB: begin
                // a + ~b + 1 so the carry out is the no-borrow bit
                wide = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
                res  = wide[DATA_W-1:0];
                ovf  = (op_a[DATA_W-1] != op_b[DATA_W-1]) && (res[DATA_W-1] != op_a[DATA_W-1]);
            end
            ALU_SHL:  res = op_a << shamt;
            ALU_SHR:  res = op_a >> shamt;
            ALU_ASHR: res = $signed(op_a) >>> shamt;
            default:  res = op_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            status_q <= '0;
        end else if (ctrl.ld_status) begin
            status_q.zero     <= (res == '0);
            status_q.carry    <= wide[DATA_W];
            status_q.negative <= res[DATA_W-1];
            status_q.overflow <= ovf;
        end
    end

    assign result_o = res;
    assign status_o = status_q;

endmodule

//--- cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              start_i,
    input  logic [DATA_W-1:0] mem_rdata_i,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output logic              halted_o
);

    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic [DATA_W-1:0] alu_result;
    status_t           status;

    ctrl_if ctrl0 ();

    // instructions sit in the low word of the data bus
    control_unit cu0 (
        .clk      (clk),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .instr_i  (mem_rdata_i[INSTR_W-1:0]),
        .status_i (status),
        .mem_rd_o (mem_rd_o),
        .mem_wr_o (mem_wr_o),
        .halted_o (halted_o),
        .ctrl     (ctrl0.cu)
    );

    reg_file #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) rf0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .ctrl         (ctrl0.rf),
        .alu_result_i (alu_result),
        .mem_rdata_i  (mem_rdata_i),
        .rd_a_o       (rd_a),
        .rd_b_o       (rd_b),
        .mem_addr_o   (mem_addr_o)
    );

    alu #(
        .DATA_W (DATA_W)
    ) alu0 (
        .clk      (clk),
        .rst_i    (rst_i),
        .ctrl     (ctrl0.alu),
        .rd_a_i   (rd_a),
        .rd_b_i   (rd_b),
        .result_o (alu_result),
        .status_o (status)
    );

    assign mem_wdata_o = rd_a;

endmodule

//--- tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// reference state of the instruction-set model
logic [31:0] m_regs [16];
status_t     m_flags;
logic [31:0] m_mem [MEM_WORDS];

function automatic bit cond_holds(input logic [3:0] cond);
    bit lt;
    lt = (m_flags.negative != m_flags.overflow);
    case (cond)
        COND_EQ:  return m_flags.zero;
        COND_NE:  return !m_flags.zero;
        COND_LTU: return !m_flags.carry;
        COND_GTU: return m_flags.carry && !m_flags.zero;
        COND_LEU: return !m_flags.carry || m_flags.zero;
        COND_GEU: return m_flags.carry;
        COND_LTS: return lt;
        COND_GTS: return !lt && !m_flags.zero;
        COND_LES: return lt || m_flags.zero;
        COND_GES: return !lt;
        default:  return 1'b1;
    endcase
endfunction

// true when the exact signed result does not fit in 32 bits
function automatic bit signed_ovf(input longint v);
    return v != longint'($signed(v[31:0]));
endfunction

// one instruction from the model pc; reports the access of the execute cycle
task automatic model_step(output bit run, output bit stop, output bit acc_rd,
                          output bit acc_wr, output logic [ADDR_W-1:0] acc_addr,
                          output logic [31:0] acc_data);
    logic [31:0] ir;
    logic [4:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] res;
    logic [31:0] i8;
    logic [31:0] i16;
    logic        c;
    logic        v;
    run      = 1'b0;
    stop     = 1'b0;
    acc_rd   = 1'b0;
    acc_wr   = 1'b0;
    acc_addr = '0;
    acc_data = '0;
    ir       = m_mem[m_regs[PC][ADDR_W-1:0]];
    m_regs[PC] = m_regs[PC] + 1;
    op  = ir[27:23];
    ra  = ir[22:19];
    rb  = ir[18:15];
    i8  = {24'h0, ir[7:0]};
    i16 = {16'h0, ir[15:0]};
    if (!cond_holds(ir[31:28]) || op == OP_NOP || op > OP_HALT) begin
        return;
    end
    if (op == OP_HALT) begin
        stop = 1'b1;
        return;
    end
    run = 1'b1;
    case (op)
        OP_LD, OP_LDR, OP_POP: begin
            acc_rd = 1'b1;
            if (op == OP_LD) begin
                acc_addr = i16[ADDR_W-1:0];
            end else if (op == OP_LDR) begin
                acc_addr = m_regs[rb][ADDR_W-1:0];
            end else begin
                acc_addr   = m_regs[SP][ADDR_W-1:0];
                m_regs[SP] = m_regs[SP] + 1;
            end
            m_regs[ra] = m_mem[acc_addr];
        end
        OP_ST, OP_STR, OP_PUSH: begin
            acc_wr   = 1'b1;
            acc_data = m_regs[ra];
            if (op == OP_ST) begin
                acc_addr = i16[ADDR_W-1:0];
            end else if (op == OP_STR) begin
                acc_addr = m_regs[rb][ADDR_W-1:0];
            end else begin
                m_regs[SP] = m_regs[SP] - 1;
                acc_addr   = m_regs[SP][ADDR_W-1:0];
            end
            m_mem[acc_addr] = acc_data;
        end
        OP_LDI: m_regs[ra] = i16;
        OP_MOV: m_regs[ra] = m_regs[rb];
        default: begin
            x = m_regs[rb];
            y = m_regs[ir[14:11]];
            if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_SUBI, OP_SHLI, OP_SHRI,
                           OP_ASHRI}) begin
                y = i8;
            end
            if (op == OP_RSUBI) begin
                x = i8;
                y = m_regs[rb];
            end
            c = 1'b0;
            v = 1'b0;
            case (op)
                OP_AND, OP_ANDI: res = x & y;
                OP_OR, OP_ORI:   res = x | y;
                OP_XOR, OP_XORI: res = x ^ y;
                OP_NOT:          res = ~x;
                OP_ADD, OP_ADDI: begin
                    res = x + y;
                    c   = (res < x);
                    v   = signed_ovf(longint'($signed(x)) + longint'($signed(y)));
                end
                OP_SUB, OP_SUBI, OP_RSUBI: begin
                    res = x - y;
                    c   = (x >= y);
                    v   = signed_ovf(longint'($signed(x)) - longint'($signed(y)));
                end
                OP_SHL, OP_SHLI: res = x << y[4:0];
                OP_SHR, OP_SHRI: res = x >> y[4:0];
                default:         res = $signed(x) >>> y[4:0];
            endcase
            m_regs[ra] = res;
            if (ir[10]) begin
                m_flags.zero     = (res == 32'h0);
                m_flags.carry    = c;
                m_flags.negative = res[31];
                m_flags.overflow = v;
            end
        end
    endcase
endtask

`endif

//--- tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 10;
    localparam int MEM_WORDS  = 1 << ADDR_W;
    localparam int CLK_PERIOD = 20;
    localparam int PROG_LEN   = 200;
    localparam int WATCHDOG_NS = 3 * PROG_LEN * 2 * CLK_PERIOD;

    logic              clk;
    logic              rst_i;
    logic              start_i;
    logic [DATA_W-1:0] mem_rdata;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_rd;
    logic              mem_wr;
    logic              halted;
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [31:0]       lfsr_q;
    int                mismatches;
    int                failures;

    `include "tb_isa_model.svh"

    cpu_top #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) dut0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .halted_o    (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign mem_rdata = mem_rd ? mem[mem_addr] : '0;

    always @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // picks r0 to r13 so sp and pc only move under FSM control
    function automatic logic [3:0] pick_reg();
        logic [31:0] r;
        r = take_bits(4);
        return 4'(r % 14);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] gotv);
        $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, expv, gotv);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        failures++;
    endtask

    task automatic build_program();
        int          n;
        logic [31:0] w;
        logic [31:0] r;
        logic [4:0]  op;
        logic [3:0]  cond;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        for (int i = 0; i < MEM_WORDS; i++) begin
            m_mem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
        end
        n = 0;
        while (n < PROG_LEN) begin
            r  = take_bits(5);
            op = r[4:0];
            if (op == OP_HALT) begin
                op = OP_ADD;
            end
            w  = take_bits(19);
            ra = pick_reg();
            rb = pick_reg();
            rc = pick_reg();
            r  = take_bits(1);
            cond = 4'h0;
            if (r[0]) begin
                r    = take_bits(4);
                cond = r[3:0];
            end
            w[18:11] = {rb, rc};
            // data area at 0x200 with random upper bits outside the address range
            if (op == OP_LD || op == OP_ST) begin
                r       = take_bits(14);
                w[15:0] = {r[13:8], 2'b10, r[7:0]};
            end
            if (op == OP_LDR || op == OP_STR) begin
                if (n == PROG_LEN - 1) begin
                    op = OP_NOP;
                end else begin
                    r        = take_bits(8);
                    m_mem[n] = {4'h0, 5'(OP_LDI), rb, 3'b000, 8'h02, r[7:0]};
                    n++;
                end
            end
            w[31:19] = {cond, op, ra};
            m_mem[n] = w;
            n++;
        end
        for (int i = 0; i < 14; i++) begin
            m_mem[n] = {4'h0, 5'(OP_ST), 4'(i), 3'b000, 16'h0300 + 16'(i)};
            n++;
        end
        m_mem[n] = {4'h0, 5'(OP_HALT), 23'h0};
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired, the CPU never halted");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        bit                run;
        bit                stop;
        bit                acc_rd;
        bit                acc_wr;
        logic [ADDR_W-1:0] acc_addr;
        logic [ADDR_W-1:0] exp_pc;
        logic [31:0]       acc_data;
        int                late;
        clk        = 1'b0;
        rst_i      = 1'b1;
        start_i    = 1'b0;
        mismatches = 0;
        failures   = 0;
        lfsr_q     = 32'h0ee9ad68;
        m_flags    = '0;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = m_mem[i];
        end
        repeat (2) @(negedge clk);
        rst_i = 1'b0;

        // idle in STOP until start
        repeat (3) begin
            @(negedge clk);
            if (halted !== 1'b1) report_mismatch("halted_o", 32'h1, 32'(halted));
            if (mem_rd !== 1'b0) report_mismatch("mem_rd_o", 32'h0, 32'(mem_rd));
            if (mem_wr !== 1'b0) report_mismatch("mem_wr_o", 32'h0, 32'(mem_wr));
        end
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;

        stop = 1'b0;
        while (!stop) begin
            exp_pc = m_regs[PC][ADDR_W-1:0];
            if (halted !== 1'b0) report_mismatch("halted_o", 32'h0, 32'(halted));
            if (mem_rd !== 1'b1) report_mismatch("mem_rd_o", 32'h1, 32'(mem_rd));
            if (mem_wr !== 1'b0) report_mismatch("mem_wr_o", 32'h0, 32'(mem_wr));
            if (mem_addr !== exp_pc) report_mismatch("mem_addr_o", 32'(exp_pc), 32'(mem_addr));
            model_step(run, stop, acc_rd, acc_wr, acc_addr, acc_data);
            @(negedge clk);
            if (run) begin
                if (mem_rd !== acc_rd) report_mismatch("mem_rd_o", 32'(acc_rd), 32'(mem_rd));
                if (mem_wr !== acc_wr) report_mismatch("mem_wr_o", 32'(acc_wr), 32'(mem_wr));
                if ((acc_rd || acc_wr) && mem_addr !== acc_addr) begin
                    report_mismatch("mem_addr_o", 32'(acc_addr), 32'(mem_addr));
                end
                if (acc_wr && mem_wdata !== acc_data) begin
                    report_mismatch("mem_wdata_o", acc_data, mem_wdata);
                end
                @(negedge clk);
            end
        end

        late = 0;
        while (!halted) begin
            @(negedge clk);
            late++;
        end
        if (late != 0) begin
            report_failure($sformatf("halted_o rose %0d cycles late after HALT", late));
        end
        repeat (4) begin
            if (mem_rd !== 1'b0) report_mismatch("mem_rd_o", 32'h0, 32'(mem_rd));
            if (mem_wr !== 1'b0) report_mismatch("mem_wr_o", 32'h0, 32'(mem_wr));
            @(negedge clk);
        end

        // register dump and data area against the model image
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem[i] !== m_mem[i]) begin
                report_mismatch($sformatf("mem[%0h]", i), m_mem[i], mem[i]);
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cpu_pkg.sv
ctrl_if.sv
control_unit.sv
reg_file.sv
alu.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cpu
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
